/* hw/tape_pkg.sv */
// ======================================================================
// Tape playback controller shared types
// Key bus, key command, player event and status structs, key codes and
// CPU speed codes used across the tape controller
// ======================================================================

package tape_pkg;

	// Host key bus as delivered by the I/O block
	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	// Transport commands decoded from function keys
	typedef enum logic [1:0] {
		KEY_NONE       = 2'd0,
		KEY_PLAY_PAUSE = 2'd1,
		KEY_REWIND     = 2'd2,
		KEY_EJECT      = 2'd3
	} key_cmd_e;

	typedef struct packed {
		logic     valid;
		key_cmd_e cmd;
	} key_cmd_t;

	// TZX player events where req is a toggle and the rest are pulses
	typedef struct packed {
		logic req;
		logic loop_start;
		logic loop_next;
		logic stop;
	} player_evt_t;

	typedef struct packed {
		logic ready;
		logic motor_on;
	} tape_status_t;

	// Scan codes with the extended flag in bit 8
	localparam logic [8:0] KEY_CODE_F5 = 9'h003;
	localparam logic [8:0] KEY_CODE_F6 = 9'h00B;
	localparam logic [8:0] KEY_CODE_F7 = 9'h083;

	// CPU speed settings
	localparam logic [1:0] SPEED_3M5 = 2'd0;
	localparam logic [1:0] SPEED_7M  = 2'd1;
	localparam logic [1:0] SPEED_14M = 2'd2;
	localparam logic [1:0] SPEED_28M = 2'd3;

endpackage

/* hw/tape_key_decoder.sv */
// ======================================================================
// Tape key decoder
// Synchronises the key strobe and maps F5/F6/F7 events to transport
// commands as a registered one-cycle pulse
// ======================================================================

`timescale 1ns/1ps

module tape_key_decoder (
	input  logic               clk_sys,
	input  logic               RESET,
	input  tape_pkg::ps2_key_t ps2_key_i,
	output tape_pkg::key_cmd_t key_cmd_o
);
	import tape_pkg::*;

	logic       stb_q1;
	logic       stb_q2;
	logic       pressed_q;
	logic [8:0] code_q;
	key_cmd_e   cmd_d;

	// Code and press flag travel alongside the first strobe stage
	always_ff @(posedge clk_sys) begin
		pressed_q <= ps2_key_i.pressed;
		code_q    <= ps2_key_i.code;
	end

	// Play/pause acts on press only, the others on either edge of the key
	always_comb begin
		cmd_d = KEY_NONE;
		case (code_q)
			KEY_CODE_F5: cmd_d = pressed_q ? KEY_PLAY_PAUSE : KEY_NONE;
			KEY_CODE_F6: cmd_d = KEY_REWIND;
			KEY_CODE_F7: cmd_d = KEY_EJECT;
			default:     cmd_d = KEY_NONE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			stb_q1          <= 1'b0;
			stb_q2          <= 1'b0;
			key_cmd_o.valid <= 1'b0;
			key_cmd_o.cmd   <= KEY_NONE;
		end else begin
			stb_q1 <= ps2_key_i.strobe;
			stb_q2 <= stb_q1;
			// New key event when the two stages disagree
			if ((stb_q1 ^ stb_q2) && (cmd_d != KEY_NONE)) begin
				key_cmd_o.valid <= 1'b1;
				key_cmd_o.cmd   <= cmd_d;
			end else begin
				key_cmd_o.valid <= 1'b0;
				key_cmd_o.cmd   <= KEY_NONE;
			end
		end
	end

endmodule

/* hw/tape_ce_gen.sv */
// ======================================================================
// Tape player clock enable generator
// Divides clk_sys by 32, 16, 8 or 4 per CPU speed, masking ticks on
// memory wait at the two fastest speeds
// ======================================================================

`timescale 1ns/1ps

module tape_ce_gen (
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic [1:0] cpu_speed_i,
	input  logic       mem_wait_i,
	output logic       tape_ce_o
);
	import tape_pkg::*;

	logic [4:0] div_q;
	logic [1:0] speed_q;
	logic       tick;

	// Tick on the last count of each period, so nothing fires straight out of reset
	always_comb begin
		case (speed_q)
			SPEED_3M5: tick = &div_q[4:0];
			SPEED_7M:  tick = &div_q[3:0];
			SPEED_14M: tick = &div_q[2:0] & ~mem_wait_i;
			SPEED_28M: tick = &div_q[1:0] & ~mem_wait_i;
			default:   tick = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			div_q     <= 5'd0;
			speed_q   <= SPEED_3M5;
			tape_ce_o <= 1'b0;
		end else begin
			div_q     <= div_q + 5'd1;
			tape_ce_o <= tick;
			// Speed only changes at the wrap so no short period appears
			if (&div_q) begin
				speed_q <= cpu_speed_i;
			end
		end
	end

endmodule

/* hw/tape_transport.sv */
// ======================================================================
// Tape transport
// Tracks tape length, ready and motor flags, and sequences the read
// addresses requested by the TZX player including loop handling
// ======================================================================

`timescale 1ns/1ps

module tape_transport #(
	parameter int ADDR_W = 25
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  tape_pkg::key_cmd_t     key_cmd_i,
	input  logic                   dl_active_i,
	input  logic [ADDR_W-1:0]      dl_addr_i,
	input  tape_pkg::player_evt_t  player_i,
	output logic                   rd_req_o,
	output logic [ADDR_W-1:0]      rd_addr_o,
	output tape_pkg::tape_status_t status_o,
	output logic                   player_restart_o
);
	import tape_pkg::*;

	logic [ADDR_W-1:0] tape_len;
	logic [ADDR_W-1:0] next_addr;
	logic [ADDR_W-1:0] loop_addr;
	tape_status_t      status_q;
	tape_status_t      status_d;
	logic              dl_q;
	logic              restart_q;

	logic key_play;
	logic key_rewind;
	logic key_eject;
	logic dl_end;
	logic req_seen;
	logic clear_addr;
	logic req_adv;

	// ==================================================================
	// Event decode
	// ==================================================================
	assign key_play   = key_cmd_i.valid && (key_cmd_i.cmd == KEY_PLAY_PAUSE);
	assign key_rewind = key_cmd_i.valid && (key_cmd_i.cmd == KEY_REWIND);
	assign key_eject  = key_cmd_i.valid && (key_cmd_i.cmd == KEY_EJECT);

	assign dl_end     = dl_q & ~dl_active_i;
	// rd_req_o mirrors the player toggle, so a mismatch is a new request
	assign req_seen   = player_i.req ^ rd_req_o;
	assign clear_addr = key_rewind | dl_active_i;
	assign req_adv    = req_seen & ~clear_addr;

	// ==================================================================
	// Ready and motor flags
	// ==================================================================
	always_comb begin
		status_d = status_q;

		if (key_eject) begin
			status_d.ready = 1'b0;
		end
		// Running off the end of the image drops ready
		if (req_adv && (next_addr >= tape_len)) begin
			status_d.ready = 1'b0;
		end
		if (dl_end) begin
			status_d.ready = 1'b1;
		end

		if (key_play && status_q.ready) begin
			status_d.motor_on = ~status_q.motor_on;
		end
		if (key_rewind || player_i.stop || dl_active_i) begin
			status_d.motor_on = 1'b0;
		end
		// Motor never runs without a loaded tape
		if (!status_d.ready) begin
			status_d.motor_on = 1'b0;
		end
		if (dl_end) begin
			status_d.motor_on = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			status_q  <= '0;
			dl_q      <= 1'b0;
			restart_q <= 1'b0;
			tape_len  <= '0;
		end else begin
			status_q  <= status_d;
			dl_q      <= dl_active_i;
			restart_q <= clear_addr;
			// Final download address is the image length
			if (dl_end) begin
				tape_len <= dl_addr_i;
			end
		end
	end

	// ==================================================================
	// Read address sequencing
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rd_req_o  <= 1'b0;
			rd_addr_o <= '0;
			next_addr <= '0;
			loop_addr <= '0;
		end else begin
			rd_req_o <= player_i.req;

			if (player_i.loop_start) begin
				loop_addr <= next_addr;
			end

			if (clear_addr) begin
				next_addr <= '0;
			end else if (player_i.loop_next) begin
				next_addr <= loop_addr + ADDR_W'(1);
			end else if (req_seen) begin
				next_addr <= next_addr + ADDR_W'(1);
			end

			// Download only restarts the pointer, the last read stays put
			if (key_rewind) begin
				rd_addr_o <= '0;
			end else if (player_i.loop_next) begin
				rd_addr_o <= loop_addr;
			end else if (req_adv) begin
				rd_addr_o <= next_addr;
			end
		end
	end

	assign status_o         = status_q;
	assign player_restart_o = ~status_q.ready | restart_q;

endmodule

/* hw/tape_ctrl_top.sv */
// ======================================================================
// Tape playback controller top level
// Key decoder feeds the transport, the enable generator runs the
// external TZX player from the CPU speed setting
// ======================================================================

`timescale 1ns/1ps

module tape_ctrl_top #(
	parameter int ADDR_W = 25
) (
	input  logic                   clk_sys,
	input  logic                   RESET,

	// Host side
	input  tape_pkg::ps2_key_t     ps2_key_i,
	input  logic                   dl_active_i,
	input  logic [ADDR_W-1:0]      dl_addr_i,

	// Player and tape memory
	input  tape_pkg::player_evt_t  player_i,
	output logic                   rd_req_o,
	output logic [ADDR_W-1:0]      rd_addr_o,
	output tape_pkg::tape_status_t status_o,
	output logic                   player_restart_o,

	// Core timing
	input  logic [1:0]             cpu_speed_i,
	input  logic                   mem_wait_i,
	output logic                   tape_ce_o
);
	import tape_pkg::*;

	key_cmd_t     key_cmd;
	tape_status_t status;

	tape_key_decoder u_tape_key_decoder (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.ps2_key_i (ps2_key_i),
		.key_cmd_o (key_cmd)
	);

	tape_transport #(
		.ADDR_W (ADDR_W)
	) u_tape_transport (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.key_cmd_i        (key_cmd),
		.dl_active_i      (dl_active_i),
		.dl_addr_i        (dl_addr_i),
		.player_i         (player_i),
		.rd_req_o         (rd_req_o),
		.rd_addr_o        (rd_addr_o),
		.status_o         (status),
		.player_restart_o (player_restart_o)
	);

	// Motor gating of the player happens outside, through status_o
	assign status_o = status;

	tape_ce_gen u_tape_ce_gen (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cpu_speed_i (cpu_speed_i),
		.mem_wait_i  (mem_wait_i),
		.tape_ce_o   (tape_ce_o)
	);

endmodule

/* tests/tape_ctrl_sva.sv */
// ======================================================================
// Tape transport assertions
// Address sequencing, motor/ready consistency and key pulse width
// ======================================================================

`timescale 1ns/1ps

module tape_transport_sva #(
	parameter int ADDR_W = 25
) (
	input logic                   clk_sys,
	input logic                   RESET,
	input tape_pkg::key_cmd_t     key_cmd_i,
	input tape_pkg::player_evt_t  player_i,
	input logic                   rd_req_o,
	input logic [ADDR_W-1:0]      rd_addr_o,
	input tape_pkg::tape_status_t status_o
);
	import tape_pkg::*;

	// Read address moves only on a request, a loop jump, a rewind or reset
	a_addr_change: assert property (@(posedge clk_sys) disable iff (RESET)
		!$stable(rd_addr_o) |-> (!$stable(rd_req_o) || $past(player_i.loop_next) ||
			$past(key_cmd_i.valid && (key_cmd_i.cmd == KEY_REWIND)) || $past(RESET)))
		else $error("rd_addr_o changed without request, loop or rewind");

	a_motor_ready: assert property (@(posedge clk_sys) disable iff (RESET)
		status_o.motor_on |-> status_o.ready)
		else $error("motor running while tape not ready");

	a_key_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		key_cmd_i.valid |=> !key_cmd_i.valid)
		else $error("key command valid held for two cycles");

endmodule

bind tape_transport tape_transport_sva #(.ADDR_W(ADDR_W)) u_tape_transport_sva (.*);

/* tests/tape_ctrl_tb.sv */
// ======================================================================
// Tape playback controller testbench
// Random downloads, reads, keys, loops and enable rates checked
// against a reference model of the transport
// ======================================================================

`timescale 1ns/1ps

module tape_ctrl_tb;
	import tape_pkg::*;

	localparam int ADDR_W     = 25;
	localparam int CLK_PERIOD = 100;
	localparam int N_KEYS     = 12;
	localparam int N_LOOPS    = 4;
	localparam int CYC_EVT    = 8;
	localparam int CYC_DL     = 12;
	localparam int CYC_CE     = 64 + 256 + 2;
	localparam int PLANNED    = 8 + CYC_DL + 41 * CYC_EVT + N_KEYS * (CYC_DL + 4 * CYC_EVT)
		+ N_LOOPS * (CYC_DL + 10 * CYC_EVT) + 8 * CYC_CE;

	logic              clk_sys;
	logic              RESET;
	ps2_key_t          ps2_key;
	logic              dl_active;
	logic [ADDR_W-1:0] dl_addr;
	player_evt_t       player;
	logic [1:0]        cpu_speed;
	logic              mem_wait;
	logic              rd_req;
	logic [ADDR_W-1:0] rd_addr;
	tape_status_t      status;
	logic              player_restart;
	logic              tape_ce;

	// Reference model state
	logic              m_ready;
	logic              m_motor;
	logic              m_req;
	logic [ADDR_W-1:0] m_next;
	logic [ADDR_W-1:0] m_loop;
	logic [ADDR_W-1:0] m_len;
	logic [ADDR_W-1:0] m_rd_addr;

	logic [31:0] lcg_state;
	int          err_count;
	int          check_count;
	int          test_count;
	int          test_err_start;

	tape_ctrl_top #(
		.ADDR_W (ADDR_W)
	) u_tape_ctrl_top (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ps2_key_i        (ps2_key),
		.dl_active_i      (dl_active),
		.dl_addr_i        (dl_addr),
		.player_i         (player),
		.rd_req_o         (rd_req),
		.rd_addr_o        (rd_addr),
		.status_o         (status),
		.player_restart_o (player_restart),
		.cpu_speed_i      (cpu_speed),
		.mem_wait_i       (mem_wait),
		.tape_ce_o        (tape_ce)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(PLANNED * 3 / 2 * CLK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("STATUS: FAIL");
		$finish;
	end

	// ==================================================================
	// Random numbers and compare tasks
	// ==================================================================
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = next_random();
		return lo + int'((r >> 8) % (hi - lo + 1));
	endfunction

	task automatic check_status(input tape_status_t got, input tape_status_t exp,
			input string name);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
			input string name);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_ce_count(input int got, input int exp, input string name);
		check_count++;
		if (got != exp) begin
			err_count++;
			$display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic settle_and_check();
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		check_status(status, '{ready: m_ready, motor_on: m_motor}, "status_o");
		check_addr(rd_addr, m_rd_addr, "rd_addr_o");
		check_bit(rd_req, m_req, "rd_req_o");
		check_bit(player_restart, ~m_ready, "player_restart_o");
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("test %-10s done, %0d errors", name, err_count - test_err_start);
		test_err_start = err_count;
	endtask

	// ==================================================================
	// Stimulus tasks that also update the model
	// ==================================================================
	task automatic load_tape(input int len);
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_addr   <= '0;
		@(posedge clk_sys);
		dl_addr   <= ADDR_W'(len / 2);
		@(posedge clk_sys);
		dl_addr   <= ADDR_W'(len);
		@(posedge clk_sys);
		dl_active <= 1'b0;
		m_next  = '0;
		m_len   = ADDR_W'(len);
		m_ready = 1'b1;
		m_motor = 1'b1;
		settle_and_check();
	endtask

	task automatic player_request();
		@(posedge clk_sys);
		player.req <= ~player.req;
		if (m_next >= m_len) begin
			m_ready = 1'b0;
			m_motor = 1'b0;
		end
		m_rd_addr = m_next;
		m_next    = m_next + 1;
		m_req     = ~m_req;
		settle_and_check();
	endtask

	task automatic pulse_player(input logic loop_start, input logic loop_next,
			input logic stop);
		@(posedge clk_sys);
		player.loop_start <= loop_start;
		player.loop_next  <= loop_next;
		player.stop       <= stop;
		@(posedge clk_sys);
		player.loop_start <= 1'b0;
		player.loop_next  <= 1'b0;
		player.stop       <= 1'b0;
		if (loop_start) begin
			m_loop = m_next;
		end
		if (loop_next) begin
			m_rd_addr = m_loop;
			m_next    = m_loop + 1;
		end
		if (stop) begin
			m_motor = 1'b0;
		end
		settle_and_check();
	endtask

	task automatic press_key(input logic [8:0] code, input logic pressed);
		@(posedge clk_sys);
		ps2_key.strobe  <= ~ps2_key.strobe;
		ps2_key.pressed <= pressed;
		ps2_key.code    <= code;
		if ((code == KEY_CODE_F5) && pressed && m_ready) begin
			m_motor = ~m_motor;
		end else if (code == KEY_CODE_F6) begin
			m_motor   = 1'b0;
			m_next    = '0;
			m_rd_addr = '0;
		end else if (code == KEY_CODE_F7) begin
			m_ready = 1'b0;
			m_motor = 1'b0;
		end
		settle_and_check();
	endtask

	task automatic measure_ce(input logic [1:0] speed, input logic wait_on);
		int count;
		int exp;
		@(posedge clk_sys);
		cpu_speed <= speed;
		mem_wait  <= wait_on;
		// Long enough for the divider to wrap and latch the speed
		repeat (64) @(posedge clk_sys);
		count = 0;
		repeat (256) begin
			@(negedge clk_sys);
			if (tape_ce) begin
				count++;
			end
		end
		if (wait_on && (speed >= SPEED_14M)) begin
			exp = 0;
		end else begin
			exp = 256 / (32 >> speed);
		end
		check_ce_count(count, exp, $sformatf("tape_ce_o count speed %0d wait %0d",
			speed, wait_on));
	endtask

	// ==================================================================
	// Test sequence
	// ==================================================================
	initial begin
		logic [8:0] code;
		int         len;
		int         pick;
		int         start_speed;

		RESET     = 1'b1;
		ps2_key   = '0;
		dl_active = 1'b0;
		dl_addr   = '0;
		player    = '0;
		cpu_speed = SPEED_3M5;
		mem_wait  = 1'b0;
		m_ready   = 1'b0;
		m_motor   = 1'b0;
		m_req     = 1'b0;
		m_next    = '0;
		m_loop    = '0;
		m_len     = '0;
		m_rd_addr = '0;
		lcg_state = 32'h98ee;
		err_count      = 0;
		check_count    = 0;
		test_count     = 0;
		test_err_start = 0;

		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_bit(tape_ce, 1'b0, "tape_ce_o");
		settle_and_check();
		finish_test("reset");

		len = rand_range(8, 40);
		load_tape(len);
		finish_test("download");

		// Read until the request past the end drops ready
		for (int i = 0; i <= len; i++) begin
			player_request();
		end
		finish_test("read");

		for (int k = 0; k < N_KEYS; k++) begin
			if (!m_ready) begin
				load_tape(rand_range(8, 40));
			end
			pick = rand_range(0, 3);
			for (int r = 0; r < pick; r++) begin
				player_request();
			end
			case (rand_range(0, 4))
				0: press_key(KEY_CODE_F5, 1'b1);
				1: press_key(KEY_CODE_F5, 1'b0);
				2: press_key(KEY_CODE_F6, rand_range(0, 1) == 1);
				3: press_key(KEY_CODE_F7, rand_range(0, 1) == 1);
				default: begin
					code = 9'(next_random() >> 12);
					while ((code == KEY_CODE_F5) || (code == KEY_CODE_F6) ||
							(code == KEY_CODE_F7)) begin
						code = 9'(next_random() >> 12);
					end
					press_key(code, rand_range(0, 1) == 1);
				end
			endcase
		end
		finish_test("keys");

		for (int l = 0; l < N_LOOPS; l++) begin
			load_tape(rand_range(8, 40));
			pick = rand_range(1, 3);
			for (int r = 0; r < pick; r++) begin
				player_request();
			end
			pulse_player(1'b1, 1'b0, 1'b0);
			pick = rand_range(1, 3);
			for (int r = 0; r < pick; r++) begin
				player_request();
			end
			pulse_player(1'b0, 1'b1, 1'b0);
			player_request();
			pulse_player(1'b0, 1'b0, 1'b1);
		end
		finish_test("loop_stop");

		start_speed = rand_range(0, 3);
		for (int s = 0; s < 4; s++) begin
			measure_ce(2'((start_speed + s) % 4), 1'b0);
			measure_ce(2'((start_speed + s) % 4), 1'b1);
		end
		finish_test("clk_enable");

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* tb.f */
hw/tape_pkg.sv
hw/tape_key_decoder.sv
hw/tape_ce_gen.sv
hw/tape_transport.sv
hw/tape_ctrl_top.sv
tests/tape_ctrl_sva.sv
tests/tape_ctrl_tb.sv

/* Bender.yml */
package:
  name: tape_ctrl

sources:
  # RTL in compile order
  - hw/tape_pkg.sv
  - hw/tape_key_decoder.sv
  - hw/tape_ce_gen.sv
  - hw/tape_transport.sv
  - hw/tape_ctrl_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tests/tape_ctrl_sva.sv
      - tests/tape_ctrl_tb.sv
